// ==== Makefile ====
TOP = tb_command_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "no result line in $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== design/command_pkg.sv ====
`include "command_settings.svh"

package command_pkg;

	typedef enum logic [`CC_W-1:0] {
		CMD_LOOPBACK = `CC_W'(`CC_LOOPBACK), // echo payload
		CMD_RD_REG   = `CC_W'(`CC_RD_REG),   // register read
		CMD_WR_REG   = `CC_W'(`CC_WR_REG)    // register write
	} cmd_code_t;

	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;                // register number
	typedef logic [`NUM_REGS-2:0][`WORD_W-1:0] reg_bank_t;     // writable registers 1 and up

	// where the transmit word comes from
	typedef enum logic [2:0] {
		SRC_NONE, SRC_SERIAL, SRC_COMMAND, SRC_INV_CMD, SRC_RX_DATA, SRC_REG_DATA
	} reply_src_t;

	typedef struct packed {
		logic       valid;                    // handler offers a tx word
		logic       last;                     // it ends the reply
		reply_src_t src;                      // mux select
	} reply_ctrl_t;

	typedef struct packed {
		logic run;                            // start pulse from the dispatcher
		logic running;                        // handler busy
		logic done;                           // handler finished, one cycle
	} handler_ctl_t;

	typedef enum logic [2:0] {CS_IDLE, CS_COMMAND, CS_RUN, CS_WAIT, CS_DRAIN} cmd_state_t;
	typedef enum logic [2:0] {LB_IDLE, LB_SERIAL, LB_COMMAND, LB_DATA, LB_DONE} lb_state_t;
	typedef enum logic [3:0] {
		RA_IDLE, RA_NUMBER, RA_DATA_IN, RA_READ, RA_SERIAL,
		RA_COMMAND, RA_REG_DATA, RA_INV_CMD, RA_DONE
	} ra_state_t;

endpackage

// ==== design/command_settings.svh ====
`ifndef COMMAND_SETTINGS_SVH
`define COMMAND_SETTINGS_SVH

// stream word
`define WORD_W      32          // width of a receive or transmit word

// register bank
`define NUM_REGS    8           // register 0 plus the read/write registers
`define REG_ADDR_W  3           // bits of a register number

// command codes, low bits of the command word
`define CC_W        5           // width of the code field
`define CC_LOOPBACK 1           // echo the payload
`define CC_RD_REG   2           // read one register
`define CC_WR_REG   3           // write one register

`endif

// ==== design/command_sm.sv ====
`timescale 1ns/10ps
`include "command_settings.svh"

module command_sm (
	input  logic                      clk,
	input  logic                      reset,
	input  frame_pkg::rx_beat_t       rx,            // receive stream
	output logic                      rx_take,       // we accept the rx word
	output frame_pkg::word_t          serial,        // serial number of the frame
	output frame_pkg::word_t          command,       // command word of the frame
	output logic                      cmd_last,      // command word ended the frame
	output logic                      loopback_run,  // start the loopback handler
	input  command_pkg::handler_ctl_t loopback_ctl,  // loopback run/running/done
	output logic                      reg_run,       // start the register handler
	input  command_pkg::handler_ctl_t reg_ctl,       // register run/running/done
	output logic                      sm_idle        // waiting for a serial word
);
	import command_pkg::*;

	cmd_state_t state;
	cmd_state_t next_state;
	cmd_code_t  new_code;                            // code of the word now on rx
	cmd_code_t  held_code;                           // code of the latched command
	logic       accept;                              // rx word moves this cycle

	assign accept    = rx.valid && rx_take;
	assign new_code  = cmd_code_t'(rx.data[`CC_W-1:0]);
	assign held_code = cmd_code_t'(command[`CC_W-1:0]);

	//////////////////////////////////////////////////////////////////////
	// header receive and dispatch
	always_comb begin
		next_state = state;
		rx_take    = 1'b0;
		case (state)
			CS_IDLE: begin
				rx_take = 1'b1;                          // serial number word
				if (rx.valid && !rx.last)
					next_state = CS_COMMAND;
			end
			CS_COMMAND: begin
				rx_take = 1'b1;                          // command word
				if (rx.valid) begin
					case (new_code)
						CMD_LOOPBACK: next_state = CS_RUN;  // may have no payload
						CMD_RD_REG, CMD_WR_REG: begin
							if (rx.last)
								next_state = CS_IDLE;           // no register number, drop
							else
								next_state = CS_RUN;
						end
						default: begin
							if (rx.last)
								next_state = CS_IDLE;
							else
								next_state = CS_DRAIN;          // unknown code, eat the rest
						end
					endcase
				end
			end
			CS_RUN: next_state = CS_WAIT;               // run pulse goes out here
			CS_WAIT: begin
				if (loopback_ctl.done || reg_ctl.done)
					next_state = CS_IDLE;
			end
			CS_DRAIN: begin
				rx_take = 1'b1;
				if (rx.valid && rx.last)
					next_state = CS_IDLE;
			end
			default: next_state = CS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= CS_IDLE;
		else
			state <= next_state;
	end

	// header words, loaded as they are taken
	always_ff @(posedge clk) begin
		if (accept && state == CS_IDLE)
			serial <= rx.data;
		if (accept && state == CS_COMMAND) begin
			command  <= rx.data;
			cmd_last <= rx.last;                     // loopback with no payload
		end
	end

	assign loopback_run = (state == CS_RUN) && (held_code == CMD_LOOPBACK);
	assign reg_run      = (state == CS_RUN) && (held_code == CMD_RD_REG || held_code == CMD_WR_REG);
	assign sm_idle      = (state == CS_IDLE);

	// a new command never starts on top of a busy handler
	a_run_when_free: assert property (@(posedge clk) disable iff (reset)
		(loopback_ctl.run || reg_ctl.run) |-> !(loopback_ctl.running || reg_ctl.running));

endmodule

// ==== design/command_top.sv ====
`timescale 1ns/10ps

module command_top (
	input  logic                   clk,
	input  logic                   reset,
	input  frame_pkg::rx_beat_t    rx,           // command frames
	output logic                   rx_ready,
	output frame_pkg::tx_beat_t    tx,           // reply frames
	input  logic                   tx_ready,
	input  logic [2:0]             ch_addr,      // channel address jumpers
	output command_pkg::reg_bank_t settings,     // writable registers
	output logic                   sm_idle       // dispatcher waiting for a frame
);
	import frame_pkg::*;
	import command_pkg::*;

	word_t        serial;
	word_t        command;
	word_t        reg_data;
	logic         cmd_last;
	logic         cmd_take, loopback_take, reg_take;
	logic         loopback_run, loopback_running, loopback_done;
	logic         reg_run, reg_running, reg_done;
	handler_ctl_t loopback_ctl;
	handler_ctl_t reg_ctl;
	reply_ctrl_t  loopback_reply;
	reply_ctrl_t  reg_reply;
	reg_addr_t    reg_num;
	logic         rd_en, wr_en, illegal;

	assign loopback_ctl = '{run: loopback_run, running: loopback_running, done: loopback_done};
	assign reg_ctl      = '{run: reg_run, running: reg_running, done: reg_done};

	command_sm i_command_sm (
		.clk, .reset, .rx, .rx_take(cmd_take), .serial, .command, .cmd_last,
		.loopback_run, .loopback_ctl, .reg_run, .reg_ctl, .sm_idle
	);

	loopback_sm i_loopback_sm (
		.clk, .reset, .run(loopback_run), .running(loopback_running), .done(loopback_done),
		.rx, .rx_take(loopback_take), .tx_ready, .reply(loopback_reply), .cmd_last
	);

	// read and write codes differ only in bit 0, write is odd
	reg_access_sm i_reg_access_sm (
		.clk, .reset, .run(reg_run), .is_write(command[0]), .running(reg_running),
		.done(reg_done), .rx, .rx_take(reg_take), .tx_ready, .reply(reg_reply),
		.reg_num, .rd_en, .wr_en, .illegal
	);

	register_block i_register_block (
		.clk, .reset, .ch_addr, .reg_num, .rd_en, .wr_en, .wr_data(rx.data),
		.rd_data(reg_data), .illegal, .settings
	);

	reply_mux i_reply_mux (
		.clk, .reset, .loopback_reply, .reg_reply, .cmd_take, .loopback_take, .reg_take,
		.serial, .command, .rx_data(rx.data), .reg_data, .tx, .rx_ready
	);

endmodule

// ==== design/frame_pkg.sv ====
`include "command_settings.svh"

package frame_pkg;

	typedef logic [`WORD_W-1:0] word_t;      // one stream word

	// receive beat, valid holds its word until taken
	typedef struct packed {
		word_t data;                          // payload word
		logic  last;                          // final word of the frame
		logic  valid;                         // word is present
	} rx_beat_t;

	// transmit beat, same layout
	typedef struct packed {
		word_t data;                          // reply word
		logic  last;                          // final word of the reply
		logic  valid;                         // word is present
	} tx_beat_t;

endpackage

// ==== design/loopback_sm.sv ====
`timescale 1ns/10ps

module loopback_sm (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     run,        // start pulse
	output logic                     running,    // busy with a frame
	output logic                     done,       // one cycle after the last echo
	input  frame_pkg::rx_beat_t      rx,         // payload words
	output logic                     rx_take,    // take rx only while tx takes the echo
	input  logic                     tx_ready,
	output command_pkg::reply_ctrl_t reply,      // tx control toward the mux
	input  logic                     cmd_last    // frame ended on the command word
);
	import command_pkg::*;

	lb_state_t state;
	lb_state_t next_state;

	always_comb begin
		next_state  = state;
		rx_take     = 1'b0;
		reply.valid = 1'b0;
		reply.last  = 1'b0;
		reply.src   = SRC_NONE;
		case (state)
			LB_IDLE: begin
				if (run)
					next_state = LB_SERIAL;
			end
			LB_SERIAL: begin
				reply.valid = 1'b1;
				reply.src   = SRC_SERIAL;
				if (tx_ready)
					next_state = LB_COMMAND;
			end
			LB_COMMAND: begin
				reply.valid = 1'b1;
				reply.last  = cmd_last;              // empty payload ends here
				reply.src   = SRC_COMMAND;
				if (tx_ready)
					next_state = cmd_last ? LB_DONE : LB_DATA;
			end
			LB_DATA: begin
				reply.valid = rx.valid;              // echo passes straight through
				reply.last  = rx.last;
				reply.src   = SRC_RX_DATA;
				rx_take     = tx_ready;
				if (rx.valid && tx_ready && rx.last)
					next_state = LB_DONE;
			end
			LB_DONE: next_state = LB_IDLE;
			default: next_state = LB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= LB_IDLE;
		else
			state <= next_state;
	end

	assign running = (state != LB_IDLE);
	assign done    = (state == LB_DONE);

endmodule

// ==== design/reg_access_sm.sv ====
`timescale 1ns/10ps
`include "command_settings.svh"

module reg_access_sm (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     run,        // start pulse
	input  logic                     is_write,   // frame is a write and is sampled with run
	output logic                     running,
	output logic                     done,
	input  frame_pkg::rx_beat_t      rx,         // register number and then write data
	output logic                     rx_take,
	input  logic                     tx_ready,
	output command_pkg::reply_ctrl_t reply,
	output command_pkg::reg_addr_t   reg_num,    // latched register number
	output logic                     rd_en,      // read strobe to the bank
	output logic                     wr_en,      // write strobe with the rx word as data
	input  logic                     illegal     // bank has no such register
);
	import command_pkg::*;

	ra_state_t state;
	ra_state_t next_state;
	logic      write_op;                         // current frame is a write
	logic      high_bits;                        // number word beyond the field width
	logic      bad_num;                          // no register behind the number

	assign bad_num = high_bits || illegal;

	//////////////////////////////////////////////////////////////////////
	// payload intake and reply sequence
	always_comb begin
		next_state  = state;
		rx_take     = 1'b0;
		rd_en       = 1'b0;
		wr_en       = 1'b0;
		reply.valid = 1'b0;
		reply.last  = 1'b0;
		reply.src   = SRC_NONE;
		case (state)
			RA_IDLE: begin
				if (run)
					next_state = RA_NUMBER;
			end
			RA_NUMBER: begin
				rx_take = 1'b1;
				if (rx.valid) begin
					if (!write_op)
						next_state = RA_READ;
					else if (rx.last)
						next_state = RA_SERIAL;            // write without data skips the strobe
					else
						next_state = RA_DATA_IN;
				end
			end
			RA_DATA_IN: begin
				rx_take = 1'b1;
				wr_en   = rx.valid && !bad_num;          // write as the data word moves
				if (rx.valid)
					next_state = RA_SERIAL;
			end
			RA_READ: begin
				rd_en      = !bad_num;                   // data ready next cycle
				next_state = RA_SERIAL;
			end
			RA_SERIAL: begin
				reply.valid = 1'b1;
				reply.src   = SRC_SERIAL;
				if (tx_ready)
					next_state = RA_COMMAND;
			end
			RA_COMMAND: begin
				reply.valid = 1'b1;
				reply.src   = SRC_COMMAND;
				if (tx_ready)
					next_state = (!write_op && !bad_num) ? RA_REG_DATA : RA_INV_CMD;
			end
			RA_REG_DATA: begin
				reply.valid = 1'b1;
				reply.src   = SRC_REG_DATA;
				if (tx_ready)
					next_state = RA_INV_CMD;
			end
			RA_INV_CMD: begin
				reply.valid = 1'b1;
				reply.last  = 1'b1;                      // closes every register reply
				reply.src   = SRC_INV_CMD;
				if (tx_ready)
					next_state = RA_DONE;
			end
			RA_DONE: next_state = RA_IDLE;
			default: next_state = RA_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= RA_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (run)
			write_op <= is_write;
		if (state == RA_NUMBER && rx.valid) begin
			reg_num   <= rx.data[`REG_ADDR_W-1:0];
			high_bits <= |rx.data[`WORD_W-1:`REG_ADDR_W];
		end
	end

	assign running = (state != RA_IDLE);
	assign done    = (state == RA_DONE);

	// a waiting rx word stays put until this handler takes it
	a_rx_held: assert property (@(posedge clk) disable iff (reset)
		(running && rx.valid && !rx_take) |=> (rx.valid && $stable(rx.data)));

endmodule

// ==== design/register_block.sv ====
`timescale 1ns/10ps
`include "command_settings.svh"

module register_block (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [2:0]             ch_addr,      // channel address jumpers
	input  command_pkg::reg_addr_t reg_num,      // register to access
	input  logic                   rd_en,
	input  logic                   wr_en,
	input  frame_pkg::word_t       wr_data,
	output frame_pkg::word_t       rd_data,      // valid the cycle after rd_en
	output logic                   illegal,      // number out of range
	output command_pkg::reg_bank_t settings      // toward the acquisition logic
);
	import frame_pkg::*;
	import command_pkg::*;

	logic [2:0] ch_addr_fixed;                   // jumpers after correction
	reg_bank_t  bank;                            // registers 1 and up
	reg_addr_t  slot;                            // bank index for reg_num

	assign slot    = reg_num - `REG_ADDR_W'(1);
	assign illegal = int'(reg_num) >= `NUM_REGS;

	// one channel has its jumpers set to 110 instead of 011
	always_ff @(posedge clk) begin
		if (ch_addr == 3'b110)
			ch_addr_fixed <= 3'b011;
		else
			ch_addr_fixed <= ch_addr;
	end

	//////////////////////////////////////////////////////////////////////
	// register bank, register 0 is read only
	always_ff @(posedge clk) begin
		if (reset)
			bank <= '0;
		else if (wr_en && !illegal && reg_num != '0)
			bank[slot] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			if (reg_num == '0)
				rd_data <= word_t'(ch_addr_fixed);   // channel address, zero extended
			else
				rd_data <= bank[slot];
		end
	end

	assign settings = bank;

endmodule

// ==== design/reply_mux.sv ====
`timescale 1ns/10ps

module reply_mux (
	input  logic                     clk,
	input  logic                     reset,
	input  command_pkg::reply_ctrl_t loopback_reply, // loopback handler control
	input  command_pkg::reply_ctrl_t reg_reply,      // register handler control
	input  logic                     cmd_take,       // dispatcher takes header words
	input  logic                     loopback_take,
	input  logic                     reg_take,
	input  frame_pkg::word_t         serial,
	input  frame_pkg::word_t         command,
	input  frame_pkg::word_t         rx_data,        // word on the receive stream
	input  frame_pkg::word_t         reg_data,       // register bank read data
	output frame_pkg::tx_beat_t      tx,
	output logic                     rx_ready
);
	import command_pkg::*;

	reply_ctrl_t sel;                            // control of the active handler

	// only one handler runs, the idle one holds valid low
	assign sel      = loopback_reply.valid ? loopback_reply : reg_reply;
	assign rx_ready = cmd_take || loopback_take || reg_take;

	//////////////////////////////////////////////////////////////////////
	// transmit word select
	always_comb begin
		tx.valid = sel.valid;
		tx.last  = sel.last;
		case (sel.src)
			SRC_SERIAL:   tx.data = serial;
			SRC_COMMAND:  tx.data = command;
			SRC_INV_CMD:  tx.data = ~command;        // closes register replies
			SRC_RX_DATA:  tx.data = rx_data;         // loopback echo
			SRC_REG_DATA: tx.data = reg_data;
			default:      tx.data = '0;
		endcase
	end

	// two handlers never offer a word at once
	a_one_source: assert property (@(posedge clk) disable iff (reset)
		!(loopback_reply.valid && reg_reply.valid));

endmodule

// ==== sim/tb_command_top.sv ====
`timescale 1ns/10ps
`include "command_settings.svh"

module tb_command_top;
	import frame_pkg::*;
	import command_pkg::*;

	localparam int N_FRAMES      = 200;                    // random frame picks
	localparam int DIRECTED      = 12;                     // frames before the random part
	localparam int MAX_PAYLOAD   = 7;                      // loopback payload words
	localparam int MAX_FRAME_LEN = MAX_PAYLOAD + 4;        // header, payload and slack
	localparam int CYCLE_LIMIT   = (2 * N_FRAMES + DIRECTED) * MAX_FRAME_LEN * 8;

	logic        clk = 1'b0;
	logic        reset;
	rx_beat_t    rx;
	logic        rx_ready;
	tx_beat_t    tx;
	logic        tx_ready;
	logic [2:0]  ch_addr;
	reg_bank_t   settings;
	logic        sm_idle;

	logic [15:0] lfsr = 16'd51386;                         // random source state
	logic [32:0] rx_q[$];                                  // {data, last} still to send
	logic [32:0] exp_q[$];                                 // {data, last} still to receive
	word_t       reg_model [`NUM_REGS];                    // entry 0 unused
	logic [2:0]  jumpers = 3'b000;                         // mirror of ch_addr
	logic        rx_pending = 1'b0;                        // a word sits on rx
	int          cycles = 0;
	int          frames = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	always #10 clk = ~clk;

	command_top i_dut (
		.clk, .reset, .rx, .rx_ready, .tx, .tx_ready, .ch_addr, .settings, .sm_idle
	);

	//////////////////////////////////////////////////////////////////////
	// random numbers with one galois step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic word_t make_cmd(input logic [4:0] code);
		return {27'(rand_bits(27)), code};                 // random upper bits
	endfunction

	function automatic word_t random_reg_num();
		if (rand_bits(3) == 0)
			return rand_bits(32) | 32'h8;                   // beyond the bank
		return rand_bits(3);
	endfunction

	function automatic logic [2:0] corrected_address(input logic [2:0] j);
		return (j == 3'b110) ? 3'b011 : j;                 // miswired channel
	endfunction

	function automatic void push_rx(input word_t data, input logic last);
		rx_q.push_back({data, last});
	endfunction

	function automatic void push_exp(input word_t data, input logic last);
		exp_q.push_back({data, last});
	endfunction

	function automatic void push_both(input word_t data, input logic last);
		push_rx(data, last);
		push_exp(data, last);                              // header or echo
	endfunction

	//////////////////////////////////////////////////////////////////////
	// one clock that checks tx and then drives rx and tx_ready
	task automatic step_cycle();
		logic [32:0] expected;
		logic [32:0] beat;
		@(posedge clk);
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			other_errors++;
			$display("timeout after %0d cycles with %0d reply words outstanding",
				cycles, exp_q.size());
			$display("** FAIL **");
			$finish;
		end else begin
			if (tx.valid) begin
				assert (!sm_idle) else begin
					value_errors++;
					$display("FAILED %0t: sm_idle is high while a reply word is on tx", $time);
				end
			end
			if (tx.valid && tx_ready) begin
				assert (exp_q.size() != 0) else begin
					other_errors++;
					$display("reply word %h was sent while no reply was expected", tx.data);
				end
				if (exp_q.size() != 0) begin
					expected = exp_q.pop_front();
					assert ({tx.data, tx.last} == expected) else begin
						value_errors++;
						$display("FAILED %0t: reply word %h last %b, expected %h last %b",
							$time, tx.data, tx.last, expected[32:1], expected[0]);
					end
				end
			end
			if (!rx.valid || rx_ready) begin               // rx word free to change
				if (rx_q.size() != 0 && rand_bits(2) != 0) begin
					beat = rx_q.pop_front();
					rx <= '{data: beat[32:1], last: beat[0], valid: 1'b1};
					rx_pending = 1'b1;
				end else begin
					rx.valid <= 1'b0;                       // gap or nothing queued
					rx_pending = 1'b0;
				end
			end
			tx_ready <= (rand_bits(2) != 0);               // stall one cycle in four
		end
	endtask

	task automatic wait_frame();
		while (!(rx_q.size() == 0 && !rx_pending && exp_q.size() == 0 && sm_idle))
			step_cycle();
		for (int i = 1; i < `NUM_REGS; i++) begin
			assert (settings[i-1] == reg_model[i]) else begin
				value_errors++;
				$display("FAILED %0t: settings register %0d is %h, expected %h",
					$time, i, settings[i-1], reg_model[i]);
			end
		end
		frames++;
	endtask

	task automatic set_jumpers(input logic [2:0] value);
		ch_addr <= value;
		jumpers = value;
		step_cycle();                                      // let the bank pick it up
	endtask

	//////////////////////////////////////////////////////////////////////
	// frame builders that fill both queues and wait for the end
	task automatic loopback_frame(input int n);
		word_t cmd;
		cmd = make_cmd(5'(`CC_LOOPBACK));
		push_both(rand_bits(32), 1'b0);
		push_both(cmd, n == 0);                            // empty payload ends here
		for (int i = 0; i < n; i++)
			push_both(rand_bits(32), i == n - 1);
		wait_frame();
	endtask

	task automatic read_frame(input word_t num);
		word_t cmd;
		cmd = make_cmd(5'(`CC_RD_REG));
		push_both(rand_bits(32), 1'b0);
		push_both(cmd, 1'b0);
		push_rx(num, 1'b1);
		if (num == 0)
			push_exp(32'(corrected_address(jumpers)), 1'b0);
		else if (num < `NUM_REGS)
			push_exp(reg_model[num[2:0]], 1'b0);
		push_exp(~cmd, 1'b1);                              // no data word when illegal
		wait_frame();
	endtask

	task automatic write_frame(input word_t num, input word_t data);
		word_t cmd;
		cmd = make_cmd(5'(`CC_WR_REG));
		push_both(rand_bits(32), 1'b0);
		push_both(cmd, 1'b0);
		push_rx(num, 1'b0);
		push_rx(data, 1'b1);
		push_exp(~cmd, 1'b1);
		if (num != 0 && num < `NUM_REGS)
			reg_model[num[2:0]] = data;                     // register 0 stays read-only
		wait_frame();
	endtask

	task automatic unknown_frame(input int n);
		logic [4:0] code;
		code = 5'(rand_bits(5));
		if (code >= 5'(`CC_LOOPBACK) && code <= 5'(`CC_WR_REG))
			code = code + 5'd8;                             // move off the known codes
		push_rx(rand_bits(32), 1'b0);
		push_rx(make_cmd(code), n == 0);
		for (int i = 0; i < n; i++)
			push_rx(rand_bits(32), i == n - 1);             // drained with no reply
		wait_frame();
	endtask

	task automatic serial_last_frame();
		push_rx(rand_bits(32), 1'b1);                      // frame of one word
		wait_frame();
	endtask

	initial begin
		logic [2:0] kind;
		word_t      num;
		for (int i = 0; i < `NUM_REGS; i++)
			reg_model[i] = '0;
		reset    <= 1'b1;
		rx       <= '0;
		tx_ready <= 1'b0;
		ch_addr  <= 3'b000;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		step_cycle();
		assert (!tx.valid) else begin
			value_errors++;
			$display("FAILED %0t: tx valid is high right after reset", $time);
		end
		assert (sm_idle) else begin
			value_errors++;
			$display("FAILED %0t: sm_idle is low right after reset", $time);
		end

		// bank after reset and then the channel address register
		for (int r = 1; r < `NUM_REGS; r++)
			read_frame(word_t'(r));
		set_jumpers(3'b110);
		read_frame('0);
		write_frame('0, rand_bits(32));
		read_frame('0);
		read_frame(32'd9);
		loopback_frame(0);

		for (int f = 0; f < N_FRAMES; f++) begin
			if (rand_bits(3) == 0)
				set_jumpers(3'(rand_bits(3)));
			kind = 3'(rand_bits(3));
			case (kind)
				3'd0, 3'd1, 3'd2: loopback_frame(int'(rand_bits(3)));
				3'd3, 3'd4: begin
					num = random_reg_num();
					write_frame(num, rand_bits(32));
					read_frame(num);                         // read back what was written
				end
				3'd5: read_frame(random_reg_num());
				3'd6: unknown_frame(int'(rand_bits(2)));
				default: serial_last_frame();
			endcase
		end
		repeat (8) step_cycle();                           // catch stray reply words

		$display("%0d frames: %0d value errors, %0d other errors",
			frames, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/frame_pkg.sv
design/command_pkg.sv
design/command_sm.sv
design/loopback_sm.sv
design/reg_access_sm.sv
design/register_block.sv
design/reply_mux.sv
design/command_top.sv
sim/tb_command_top.sv
